// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_ccip_sniffer -f vlog.f -o sim_tb &&
./obj_dir/sim_tb || exit 1

// ==== testbench/ccip_sniffer_checker.sv ====
`timescale 1ns/10ps

// Port level protocol assertions on the sniffer top
module ccip_sniffer_checker (
   input logic                  clk,
   input logic                  reset,
   input sniffer_pkg::apb_req_t apb_req,
   input sniffer_pkg::apb_rsp_t apb_rsp,
   input logic                  irq
);

   logic access;
   logic mapped;
   logic status_clear;

   // Second APB phase
   assign access = apb_req.psel && apb_req.penable;

   // The three register offsets
   assign mapped = (apb_req.paddr == sniffer_pkg::REG_STATUS) ||
                   (apb_req.paddr == sniffer_pkg::REG_FIRST_ERR) ||
                   (apb_req.paddr == sniffer_pkg::REG_ERR_COUNT);

   // Write access to the status register
   assign status_clear = access && apb_req.pwrite &&
                         (apb_req.paddr == sniffer_pkg::REG_STATUS);

   // Zero wait states
   pready_high: assert property (@(posedge clk) apb_rsp.pready)
      else $error("APB pready was low");

   // Interrupt quiet in reset and one cycle after
   irq_quiet_in_reset: assert property (@(posedge clk) reset |=> !irq)
      else $error("irq was high during or right after reset");

   // Unmapped offset errors out
   slverr_unmapped: assert property (@(posedge clk) (access && !mapped) |-> apb_rsp.pslverr)
      else $error("pslverr was low on an access to an unmapped offset");

   // Mapped offset never errors
   slverr_mapped: assert property (@(posedge clk) (access && mapped) |-> !apb_rsp.pslverr)
      else $error("pslverr was high on an access to a mapped offset");

   // Sticky interrupt, only a status write can drop it
   irq_sticky: assert property (@(posedge clk) disable iff (reset)
                                (irq && !status_clear) |=> irq)
      else $error("irq dropped without a write to the status register");

endmodule

// ==== testbench/tb_ccip_sniffer.sv ====
`timescale 1ns/10ps

// Testbench for the request interface sniffer
module tb_ccip_sniffer;

   localparam int CLK_HALF   = 10;
   localparam int POLL_LIMIT = 20;
   localparam int AW         = ccip_pkg::CL_ADDR_WIDTH;

   logic                  clk;
   logic                  reset;
   ccip_pkg::req_beat_t   c0;
   ccip_pkg::req_beat_t   c1;
   ccip_pkg::mmio_evt_t   mmio;
   sniffer_pkg::apb_req_t apb_req;
   sniffer_pkg::apb_rsp_t apb_rsp;
   logic                  irq;

   int          seed = 38454;
   string       test_name;
   logic [AW-1:0] base;
   logic [31:0] got;
   logic        slverr;
   logic        found;

   ccip_sniffer_top #(
      .TIMEOUT_CYCLES  (16),
      .ERR_COUNT_WIDTH (8)
   ) ccip_sniffer_top_inst (
      .clk     (clk),
      .reset   (reset),
      .c0      (c0),
      .c1      (c1),
      .mmio    (mmio),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .irq     (irq)
   );

   // Port assertions on every instance of the top
   bind ccip_sniffer_top ccip_sniffer_checker ccip_sniffer_checker_inst (
      .clk     (clk),
      .reset   (reset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .irq     (irq)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_HALF) clk = ~clk;
   end

   task automatic abort_run();
      $display("Something failed");
      $fatal(1, "run stopped at the first error");
   endtask

   // Status flag positions follow the violation list
   function automatic logic [31:0] status_bit(input int idx);
      return 32'd1 << idx;
   endfunction

   // Random line address on a 4-line boundary
   function automatic logic [AW-1:0] random_base();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return {r[AW-1:2], 2'b00};
   endfunction

   task automatic send_c0(input ccip_pkg::req_type_t rtype, input ccip_pkg::cl_len_t len,
                          input logic [AW-1:0] addr);
      logic [31:0] r;
      r = $random(seed);
      @(negedge clk);
      c0.valid       = 1'b1;
      c0.hdr.vc      = 2'd0;
      c0.hdr.sop     = 1'b1;
      c0.hdr.len     = len;
      c0.hdr.reqtype = rtype;
      c0.hdr.addr    = addr;
      c0.hdr.mdata   = r[15:0];
   endtask

   task automatic send_c1(input logic [1:0] vc, input logic sop, input ccip_pkg::cl_len_t len,
                          input ccip_pkg::req_type_t rtype, input logic [AW-1:0] addr);
      logic [31:0] r;
      r = $random(seed);
      @(negedge clk);
      c1.valid       = 1'b1;
      c1.hdr.vc      = vc;
      c1.hdr.sop     = sop;
      c1.hdr.len     = len;
      c1.hdr.reqtype = rtype;
      c1.hdr.addr    = addr;
      c1.hdr.mdata   = r[15:0];
   endtask

   // Drop valid on both channels
   task automatic quiet_bus();
      @(negedge clk);
      c0.valid = 1'b0;
      c1.valid = 1'b0;
   endtask

   // One cycle strobe on the MMIO lines
   task automatic pulse_mmio(input logic req, input logic rsp);
      @(negedge clk);
      mmio.rd_req = req;
      mmio.rd_rsp = rsp;
      @(negedge clk);
      mmio = '0;
   endtask

   // Setup then access, sampled mid access cycle
   task automatic fetch_reg(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
      apb_req.paddr   = addr;
      apb_req.pwdata  = '0;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #(CLK_HALF / 2);
      data = apb_rsp.prdata;
      err  = apb_rsp.pslverr;
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b1;
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      @(negedge clk);
      apb_req.penable = 1'b1;
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic check_reg(input logic [11:0] addr, input logic [31:0] exp, input string what);
      logic [31:0] data;
      logic        err;
      fetch_reg(addr, data, err);
      assert (data == exp) else begin
         $display("error %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, data);
         abort_run();
      end
   endtask

   // Single flag set, irq up, then cleared back to zero
   task automatic confirm_and_clear(input int idx);
      assert (irq) else begin
         $display("error %s irq: expected 1, actual 0", test_name);
         abort_run();
      end
      check_reg(sniffer_pkg::REG_STATUS, status_bit(idx), "status");
      write_reg(sniffer_pkg::REG_STATUS, status_bit(idx));
      check_reg(sniffer_pkg::REG_STATUS, 32'd0, "status after clear");
   endtask

   initial begin
      reset   = 1'b1;
      c0      = '0;
      c1      = '0;
      mmio    = '0;
      apb_req = '0;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      // Legal reads, writes and an answered MMIO read
      test_name = "clean_mix";
      send_c1(2'd1, 1'b1, ccip_pkg::LEN_1CL, ccip_pkg::WRLINE_M, random_base());
      base = random_base();
      for (int i = 0; i < 2; i++) begin
         send_c1(2'd2, (i == 0), ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_I, base + AW'(i));
      end
      base = random_base();
      for (int i = 0; i < 4; i++) begin
         send_c1(2'd1, (i == 0), ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_M, base + AW'(i));
      end
      quiet_bus();
      send_c0(ccip_pkg::RDLINE_I, ccip_pkg::LEN_1CL, random_base() + AW'(3));
      send_c0(ccip_pkg::RDLINE_S, ccip_pkg::LEN_4CL, random_base());
      quiet_bus();
      pulse_mmio(1'b1, 1'b0);
      repeat (5) @(negedge clk);
      pulse_mmio(1'b0, 1'b1);
      check_reg(sniffer_pkg::REG_STATUS, 32'd0, "status");
      check_reg(sniffer_pkg::REG_ERR_COUNT, 32'd0, "error count");
      assert (!irq) else begin
         $display("error %s irq: expected 0, actual 1", test_name);
         abort_run();
      end

      // Per beat rules
      test_name = "c0_write_type";
      send_c0(ccip_pkg::WRLINE_I, ccip_pkg::LEN_1CL, random_base());
      quiet_bus();
      confirm_and_clear(0);

      test_name = "c0_len3";
      send_c0(ccip_pkg::RDLINE_I, ccip_pkg::LEN_3CL, random_base());
      quiet_bus();
      confirm_and_clear(1);

      test_name = "c0_misalign";
      send_c0(ccip_pkg::RDLINE_S, ccip_pkg::LEN_4CL, random_base() + AW'(1));
      quiet_bus();
      confirm_and_clear(2);

      test_name = "c1_read_type";
      send_c1(2'd0, 1'b1, ccip_pkg::LEN_1CL, ccip_pkg::RDLINE_S, random_base());
      quiet_bus();
      confirm_and_clear(3);

      // Odd base still advances, second beat at base plus one
      test_name = "c1_misalign";
      base = random_base() + AW'(1);
      send_c1(2'd1, 1'b1, ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_I, base);
      send_c1(2'd1, 1'b0, ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_I, base + AW'(1));
      quiet_bus();
      confirm_and_clear(5);

      test_name = "c1_len3";
      send_c1(2'd1, 1'b1, ccip_pkg::LEN_3CL, ccip_pkg::WRLINE_M, random_base());
      quiet_bus();
      confirm_and_clear(4);

      // Burst sequencing
      test_name = "sop_missing";
      base = random_base();
      send_c1(2'd1, 1'b0, ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_I, base);
      send_c1(2'd1, 1'b0, ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_I, base + AW'(1));
      quiet_bus();
      confirm_and_clear(6);

      test_name = "sop_extra";
      base = random_base();
      send_c1(2'd2, 1'b1, ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_M, base);
      send_c1(2'd2, 1'b1, ccip_pkg::LEN_2CL, ccip_pkg::WRLINE_M, base + AW'(1));
      quiet_bus();
      confirm_and_clear(7);

      test_name = "addr_skip";
      base = random_base();
      send_c1(2'd1, 1'b1, ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_I, base);
      send_c1(2'd1, 1'b0, ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_I, base + AW'(1));
      send_c1(2'd1, 1'b0, ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_I, base + AW'(3));
      send_c1(2'd1, 1'b0, ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_I, base + AW'(3));
      quiet_bus();
      confirm_and_clear(8);

      test_name = "vc_change";
      base = random_base();
      for (int i = 0; i < 3; i++) begin
         send_c1(2'd1, (i == 0), ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_M, base + AW'(i));
      end
      send_c1(2'd2, 1'b0, ccip_pkg::LEN_4CL, ccip_pkg::WRLINE_M, base + AW'(3));
      quiet_bus();
      confirm_and_clear(9);

      // Unanswered MMIO read, poll until the timeout flag shows
      test_name = "mmio_timeout";
      pulse_mmio(1'b1, 1'b0);
      found = 1'b0;
      for (int i = 0; i < POLL_LIMIT && !found; i++) begin
         fetch_reg(sniffer_pkg::REG_STATUS, got, slverr);
         found = got[10];
      end
      if (!found) begin
         $display("timed out waiting for the MMIO timeout flag in the status register");
         abort_run();
      end
      // Late answer closes the read without a new flag
      pulse_mmio(1'b0, 1'b1);
      confirm_and_clear(10);

      test_name = "mmio_unsolicited";
      pulse_mmio(1'b0, 1'b1);
      confirm_and_clear(11);

      // First error, counter and partial clears
      test_name = "registers";
      write_reg(sniffer_pkg::REG_ERR_COUNT, 32'd0);
      check_reg(sniffer_pkg::REG_ERR_COUNT, 32'd0, "error count before");
      pulse_mmio(1'b0, 1'b1);
      send_c0(ccip_pkg::RDLINE_I, ccip_pkg::LEN_3CL, random_base());
      quiet_bus();
      check_reg(sniffer_pkg::REG_STATUS, status_bit(11) | status_bit(1), "status both");
      check_reg(sniffer_pkg::REG_FIRST_ERR, 32'd12, "first error");
      check_reg(sniffer_pkg::REG_ERR_COUNT, 32'd2, "error count");
      write_reg(sniffer_pkg::REG_STATUS, status_bit(1));
      check_reg(sniffer_pkg::REG_STATUS, status_bit(11), "status after partial clear");
      check_reg(sniffer_pkg::REG_FIRST_ERR, 32'd12, "first error after partial clear");
      write_reg(sniffer_pkg::REG_STATUS, status_bit(11));
      check_reg(sniffer_pkg::REG_STATUS, 32'd0, "status after full clear");
      check_reg(sniffer_pkg::REG_FIRST_ERR, 32'd0, "first error after full clear");
      write_reg(sniffer_pkg::REG_ERR_COUNT, 32'h0000_00a5);
      check_reg(sniffer_pkg::REG_ERR_COUNT, 32'd0, "error count after clear");
      fetch_reg(12'h00c, got, slverr);
      assert (slverr) else begin
         $display("error %s pslverr at 0x00c: expected 1, actual 0", test_name);
         abort_run();
      end

      $display("Everything OK");
      $finish;
   end

endmodule

// ==== verilog/ccip_pkg.sv ====
// Request interface types shared by the sniffer and its testbench
package ccip_pkg;

   // Cache-line address width
   localparam int CL_ADDR_WIDTH = 42;

   // Request type encodings, C0 takes reads and C1 takes writes and fences
   typedef enum logic [3:0] {
      WRLINE_I = 4'h1,
      WRLINE_M = 4'h2,
      RDLINE_S = 4'h4,
      WRFENCE  = 4'h5,
      RDLINE_I = 4'h6
   } req_type_t;

   // Lines per request, the 3-line code is reserved
   typedef enum logic [1:0] {
      LEN_1CL = 2'b00,
      LEN_2CL = 2'b01,
      LEN_3CL = 2'b10,
      LEN_4CL = 2'b11
   } cl_len_t;

   // Request header, same layout on C0 and C1
   typedef struct packed {
      logic [1:0]               vc;
      logic                     sop;
      cl_len_t                  len;
      req_type_t                reqtype;
      logic [CL_ADDR_WIDTH-1:0] addr;
      logic [15:0]              mdata;
   } tx_hdr_t;

   // One beat on a request channel
   typedef struct packed {
      logic    valid;
      tx_hdr_t hdr;
   } req_beat_t;

   // MMIO read strobes
   typedef struct packed {
      logic rd_req;
      logic rd_rsp;
   } mmio_evt_t;

   // Multi-line base must sit on a 2-line or 4-line boundary
   function automatic logic misaligned(cl_len_t len, logic [CL_ADDR_WIDTH-1:0] addr);
      logic bad;
      bad = 1'b0;
      if (len == LEN_2CL) begin
         bad = addr[0];
      end
      else if (len == LEN_4CL) begin
         bad = (addr[1:0] != 2'b00);
      end
      return bad;
   endfunction

endpackage

// ==== verilog/ccip_sniffer_top.sv ====
`timescale 1ns/10ps

// Protocol sniffer for the cache-line request interface
// Purely observes C0, C1 and MMIO strobes
module ccip_sniffer_top #(
   parameter int TIMEOUT_CYCLES  = 512,
   parameter int ERR_COUNT_WIDTH = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  ccip_pkg::req_beat_t   c0,
   input  ccip_pkg::req_beat_t   c1,
   input  ccip_pkg::mmio_evt_t   mmio,
   input  sniffer_pkg::apb_req_t apb_req,
   output sniffer_pkg::apb_rsp_t apb_rsp,
   output logic                  irq
);

   sniffer_pkg::violation_t viol_rule;
   sniffer_pkg::violation_t viol_burst;
   sniffer_pkg::violation_t viol_mmio;
   sniffer_pkg::violation_t viol_all;

   // Per-beat type, length and alignment rules
   request_rule_checker request_rule_checker_inst (
      .c0   (c0),
      .c1   (c1),
      .viol (viol_rule)
   );

   // C1 burst sequencing
   mcl_write_tracker mcl_write_tracker_inst (
      .clk   (clk),
      .reset (reset),
      .c1    (c1),
      .viol  (viol_burst)
   );

   // MMIO response deadline
   mmio_read_timer #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) mmio_read_timer_inst (
      .clk   (clk),
      .reset (reset),
      .mmio  (mmio),
      .viol  (viol_mmio)
   );

   // Each source owns disjoint flags
   assign viol_all = sniffer_pkg::violation_t'(viol_rule | viol_burst | viol_mmio);

   violation_log #(
      .ERR_COUNT_WIDTH (ERR_COUNT_WIDTH)
   ) violation_log_inst (
      .clk     (clk),
      .reset   (reset),
      .viol    (viol_all),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .irq     (irq)
   );

endmodule

// ==== verilog/mcl_write_tracker.sv ====
`timescale 1ns/10ps

// Follows multi-line write bursts on C1
// State value doubles as the beat index inside the burst
module mcl_write_tracker (
   input  logic                    clk,
   input  logic                    reset,
   input  ccip_pkg::req_beat_t     c1,
   output sniffer_pkg::violation_t viol
);

   // Expected beat of the current burst
   typedef enum logic [1:0] {
      FIRST  = 2'd0,
      SECOND = 2'd1,
      THIRD  = 2'd2,
      FOURTH = 2'd3
   } beat_state_t;

   beat_state_t state;
   beat_state_t state_next;

   // First-beat fields of the burst in flight
   logic [ccip_pkg::CL_ADDR_WIDTH-1:0] base_addr;
   logic [1:0]                         base_vc;
   ccip_pkg::cl_len_t                  base_len;

   logic [ccip_pkg::CL_ADDR_WIDTH-1:0] expect_addr;
   logic                               wr_beat;
   logic                               first_beat;
   logic                               later_beat;
   logic                               multi_line;

   // Fences and other types never join a burst
   assign wr_beat = c1.valid &&
                    ((c1.hdr.reqtype == ccip_pkg::WRLINE_I) ||
                     (c1.hdr.reqtype == ccip_pkg::WRLINE_M));

   assign first_beat = wr_beat && (state == FIRST);
   assign later_beat = wr_beat && (state != FIRST);

   // Lengths that open a burst
   assign multi_line = (c1.hdr.len == ccip_pkg::LEN_2CL) ||
                       (c1.hdr.len == ccip_pkg::LEN_4CL);

   // Base plus beat index
   assign expect_addr = base_addr + {{(ccip_pkg::CL_ADDR_WIDTH-2){1'b0}}, state};

   // Flags from current beat and state
   always_comb begin
      viol = '0;
      if (first_beat) begin
         viol.sop_missing = !c1.hdr.sop;
         viol.c1_len3     = (c1.hdr.len == ccip_pkg::LEN_3CL);
         viol.c1_misalign = ccip_pkg::misaligned(c1.hdr.len, c1.hdr.addr);
      end
      if (later_beat) begin
         viol.sop_extra    = c1.hdr.sop;
         viol.addr_skip    = (c1.hdr.addr != expect_addr);
         viol.field_change = (c1.hdr.vc != base_vc) || (c1.hdr.len != base_len);
      end
   end

   // Next beat, 1-line and 3-line writes stay in FIRST
   always_comb begin
      state_next = state;
      if (wr_beat) begin
         case (state)
            FIRST:   state_next = multi_line ? SECOND : FIRST;
            SECOND:  state_next = (base_len == ccip_pkg::LEN_2CL) ? FIRST : THIRD;
            THIRD:   state_next = FOURTH;
            default: state_next = FIRST;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= FIRST;
      end
      else begin
         state <= state_next;
      end
   end

   // Capture burst base on its first beat
   always_ff @(posedge clk) begin
      if (first_beat) begin
         base_addr <= c1.hdr.addr;
         base_vc   <= c1.hdr.vc;
         base_len  <= c1.hdr.len;
      end
   end

endmodule

// ==== verilog/mmio_read_timer.sv ====
`timescale 1ns/10ps

// Tracks one outstanding MMIO read and its response deadline
module mmio_read_timer #(
   parameter int TIMEOUT_CYCLES = 512
) (
   input  logic                    clk,
   input  logic                    reset,
   input  ccip_pkg::mmio_evt_t     mmio,
   output sniffer_pkg::violation_t viol
);

   localparam int CNT_WIDTH = $clog2(TIMEOUT_CYCLES + 1);
   localparam logic [CNT_WIDTH-1:0] CNT_LIMIT = CNT_WIDTH'(TIMEOUT_CYCLES);
   localparam logic [CNT_WIDTH-1:0] CNT_LAST  = CNT_WIDTH'(TIMEOUT_CYCLES - 1);

   logic                 outstanding;
   logic [CNT_WIDTH-1:0] wait_cnt;

   always_comb begin
      viol = '0;
      // Fires on the cycle the count steps onto the limit
      viol.mmio_timeout     = outstanding && (wait_cnt == CNT_LAST);
      // Response while nothing is pending
      viol.mmio_unsolicited = mmio.rd_rsp && !outstanding;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         outstanding <= 1'b0;
         wait_cnt    <= '0;
      end
      else begin
         // New request wins over a response in the same cycle
         if (mmio.rd_req) begin
            outstanding <= 1'b1;
         end
         else if (mmio.rd_rsp) begin
            outstanding <= 1'b0;
         end

         // Count outstanding cycles, park at the limit
         if (!outstanding || mmio.rd_rsp) begin
            wait_cnt <= '0;
         end
         else if (wait_cnt != CNT_LIMIT) begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== verilog/request_rule_checker.sv ====
`timescale 1ns/10ps

// Single-beat rules on C0 and request type check on C1
module request_rule_checker (
   input  ccip_pkg::req_beat_t     c0,
   input  ccip_pkg::req_beat_t     c1,
   output sniffer_pkg::violation_t viol
);

   logic c0_is_read;
   logic c0_read;
   logic c1_legal;

   // C0 only carries line reads
   assign c0_is_read = (c0.hdr.reqtype == ccip_pkg::RDLINE_I) ||
                       (c0.hdr.reqtype == ccip_pkg::RDLINE_S);
   assign c0_read    = c0.valid && c0_is_read;

   // C1 carries writes and fences
   assign c1_legal = (c1.hdr.reqtype == ccip_pkg::WRLINE_I) ||
                     (c1.hdr.reqtype == ccip_pkg::WRLINE_M) ||
                     (c1.hdr.reqtype == ccip_pkg::WRFENCE);

   always_comb begin
      viol = '0;

      // Wrong request type on the read channel
      viol.c0_bad_type = c0.valid && !c0_is_read;

      // Length and alignment only make sense on a read
      viol.c0_len3     = c0_read && (c0.hdr.len == ccip_pkg::LEN_3CL);
      viol.c0_misalign = c0_read && ccip_pkg::misaligned(c0.hdr.len, c0.hdr.addr);

      // Wrong request type on the write channel
      // Burst rules on C1 live in the write tracker
      viol.c1_bad_type = c1.valid && !c1_legal;
   end

endmodule

// ==== verilog/sniffer_pkg.sv ====
// Checker side types: violation flags, error codes and the APB register port
package sniffer_pkg;

   // APB port geometry
   localparam int APB_ADDR_WIDTH = 12;
   localparam int APB_DATA_WIDTH = 32;

   // Violation flags, last member is bit 0
   typedef struct packed {
      logic mmio_unsolicited;
      logic mmio_timeout;
      logic field_change;
      logic addr_skip;
      logic sop_extra;
      logic sop_missing;
      logic c1_misalign;
      logic c1_len3;
      logic c1_bad_type;
      logic c0_misalign;
      logic c0_len3;
      logic c0_bad_type;
   } violation_t;

   localparam int VIOL_WIDTH = $bits(violation_t);

   // Error code is flag bit index plus one
   typedef enum logic [3:0] {
      NO_ERR               = 4'd0,
      ERR_C0_BAD_TYPE      = 4'd1,
      ERR_C0_LEN3          = 4'd2,
      ERR_C0_MISALIGN      = 4'd3,
      ERR_C1_BAD_TYPE      = 4'd4,
      ERR_C1_LEN3          = 4'd5,
      ERR_C1_MISALIGN      = 4'd6,
      ERR_SOP_MISSING      = 4'd7,
      ERR_SOP_EXTRA        = 4'd8,
      ERR_ADDR_SKIP        = 4'd9,
      ERR_FIELD_CHANGE     = 4'd10,
      ERR_MMIO_TIMEOUT     = 4'd11,
      ERR_MMIO_UNSOLICITED = 4'd12
   } err_code_t;

   // APB request from the host
   typedef struct packed {
      logic                      psel;
      logic                      penable;
      logic                      pwrite;
      logic [APB_ADDR_WIDTH-1:0] paddr;
      logic [APB_DATA_WIDTH-1:0] pwdata;
   } apb_req_t;

   // APB response back to the host
   typedef struct packed {
      logic [APB_DATA_WIDTH-1:0] prdata;
      logic                      pready;
      logic                      pslverr;
   } apb_rsp_t;

   // Register map
   localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS    = 12'h000;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_FIRST_ERR = 12'h004;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_ERR_COUNT = 12'h008;

endpackage

// ==== verilog/violation_log.sv ====
`timescale 1ns/10ps

// Sticky violation status, first error code and error counter
// APB slave, zero wait states
module violation_log #(
   parameter int ERR_COUNT_WIDTH = 8
) (
   input  logic                    clk,
   input  logic                    reset,
   input  sniffer_pkg::violation_t viol,
   input  sniffer_pkg::apb_req_t   apb_req,
   output sniffer_pkg::apb_rsp_t   apb_rsp,
   output logic                    irq
);

   localparam int VW = sniffer_pkg::VIOL_WIDTH;
   localparam int DW = sniffer_pkg::APB_DATA_WIDTH;

   logic [VW-1:0]              viol_bits;
   logic                       any_flag;
   logic [VW-1:0]              status;
   logic [VW-1:0]              status_next;
   logic [VW-1:0]              clr_mask;
   sniffer_pkg::err_code_t     first_err;
   logic [ERR_COUNT_WIDTH-1:0] err_count;
   logic [ERR_COUNT_WIDTH-1:0] count_base;
   logic [ERR_COUNT_WIDTH-1:0] count_next;

   logic access;
   logic wr_access;
   logic rd_access;
   logic hit_status;
   logic hit_first;
   logic hit_count;
   logic mapped;

   // Code of the lowest set flag
   function automatic sniffer_pkg::err_code_t lowest_code(logic [VW-1:0] bits);
      sniffer_pkg::err_code_t code;
      code = sniffer_pkg::NO_ERR;
      for (int i = VW - 1; i >= 0; i--) begin
         if (bits[i]) begin
            code = sniffer_pkg::err_code_t'(4'(i + 1));
         end
      end
      return code;
   endfunction

   assign viol_bits = viol;
   assign any_flag  = |viol_bits;

   // Second APB phase
   assign access    = apb_req.psel && apb_req.penable;
   assign wr_access = access && apb_req.pwrite;
   assign rd_access = access && !apb_req.pwrite;

   // Address decode
   assign hit_status = (apb_req.paddr == sniffer_pkg::REG_STATUS);
   assign hit_first  = (apb_req.paddr == sniffer_pkg::REG_FIRST_ERR);
   assign hit_count  = (apb_req.paddr == sniffer_pkg::REG_ERR_COUNT);
   assign mapped     = hit_status || hit_first || hit_count;

   // Write-1-to-clear, a fresh flag beats its own clear
   assign clr_mask    = (wr_access && hit_status) ? apb_req.pwdata[VW-1:0] : '0;
   assign status_next = (status & ~clr_mask) | viol_bits;

   // Counter clear also yields to a fresh flag
   assign count_base = (wr_access && hit_count) ? '0 : err_count;
   always_comb begin
      count_next = count_base;
      if (any_flag && (count_base != '1)) begin
         count_next = count_base + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         status    <= '0;
         first_err <= sniffer_pkg::NO_ERR;
         err_count <= '0;
      end
      else begin
         status    <= status_next;
         err_count <= count_next;
         // Latch on the rise out of a clean status, drop once clean again
         if (status_next == '0) begin
            first_err <= sniffer_pkg::NO_ERR;
         end
         else if (status == '0) begin
            first_err <= lowest_code(viol_bits);
         end
      end
   end

   assign irq = |status;

   // Read mux, data only in a read access
   always_comb begin
      apb_rsp.prdata = '0;
      if (rd_access) begin
         if (hit_status) begin
            apb_rsp.prdata = DW'(status);
         end
         else if (hit_first) begin
            apb_rsp.prdata = DW'(first_err);
         end
         else if (hit_count) begin
            apb_rsp.prdata = DW'(err_count);
         end
      end
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && !mapped;

endmodule

// ==== vlog.f ====
verilog/ccip_pkg.sv
verilog/sniffer_pkg.sv
verilog/request_rule_checker.sv
verilog/mcl_write_tracker.sv
verilog/mmio_read_timer.sv
verilog/violation_log.sv
verilog/ccip_sniffer_top.sv
testbench/ccip_sniffer_checker.sv
testbench/tb_ccip_sniffer.sv
